//--- iwdg_bus_pkg.sv
// Bus-side definitions for the watchdog register slave.
// Bus phase enum, register select enum, data width and
// the byte addresses of the four registers.

package iwdg_bus_pkg;

  // Width of the bus data path.
  localparam int data_w = 16;

  // Register map, byte addresses.
  localparam logic [31:0] base_adr = 32'h0100_0000;
  localparam logic [31:0] kr_adr   = base_adr + 32'h0000_0000;
  localparam logic [31:0] pr_adr   = base_adr + 32'h0000_0004;
  localparam logic [31:0] rlr_adr  = base_adr + 32'h0000_0008;
  localparam logic [31:0] st_adr   = base_adr + 32'h0000_000C;

  // Phase of a bus access.
  // Idle waits for cyc, read and write are the ack cycle.
  typedef enum logic [1:0] {
    idle  = 2'd0,
    read  = 2'd1,
    write = 2'd2
  } bus_state_e;

  // Register picked by the address decoder.
  // Sel_none marks an unmapped address.
  typedef enum logic [2:0] {
    sel_kr   = 3'd0,
    sel_pr   = 3'd1,
    sel_rlr  = 3'd2,
    sel_st   = 3'd3,
    sel_none = 3'd4
  } reg_sel_e;

endpackage

//--- iwdg_reg_pkg.sv
// Watchdog-side definitions.
// Key values, register field widths, prescaler width,
// highest legal prescale code and reload reset value.

package iwdg_reg_pkg;

  // Values of the key register.
  // Key_count starts the countdown, key_reload refreshes it.
  // Key_access unlocks the prescale and reload registers.
  typedef enum logic [15:0] {
    key_idle   = 16'h0000,
    key_count  = 16'hCCCC,
    key_reload = 16'hAAAA,
    key_access = 16'h5555
  } key_e;

  // Prescale code field.
  localparam int pr_w = 3;

  // Reload value field.
  localparam int rlr_w = 12;

  // Status field.
  // Bit 0 flags a prescale update, bit 1 a reload.
  localparam int st_w = 2;

  // Prescaler counter.
  // Wide enough for the divide-by-256 setting.
  localparam int presc_w = 8;

  // Highest legal prescale code, divide by 256.
  localparam logic [pr_w-1:0] pr_max = 3'd6;

  // Reload value after reset, also the largest one.
  localparam logic [rlr_w-1:0] rlr_reset = 12'hFFF;

endpackage

//--- iwdg_bus_fsm.sv
// Bus slave control for the watchdog registers.
// Two-cycle access: cyc is sampled in idle, the next cycle is
// the ack cycle. Decodes the address into a register select
// and raises ack and the write strobe in the ack cycle.

module iwdg_bus_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [31:0]            adr,
  output logic                   ack,
  output logic                   wr_stb,
  output iwdg_bus_pkg::reg_sel_e reg_sel
);

  import iwdg_bus_pkg::*;

  bus_state_e state;
  bus_state_e state_next;
  reg_sel_e   adr_sel;

  // Address decode.
  // Anything off the map still gets an ack.
  always_comb begin
    case (adr)
      kr_adr:  adr_sel = sel_kr;
      pr_adr:  adr_sel = sel_pr;
      rlr_adr: adr_sel = sel_rlr;
      st_adr:  adr_sel = sel_st;
      default: adr_sel = sel_none;
    endcase
  end

  // Next phase.
  // Idle leaves on cyc, the access phase always lasts one cycle.
  always_comb begin
    state_next = idle;
    if (state == idle && cyc) begin
      state_next = we ? write : read;
    end
  end

  // Phase register.
  // The select is captured with the cycle and held for the access.
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle;
      reg_sel <= sel_none;
    end else begin
      state <= state_next;
      if (state == idle && cyc) begin
        reg_sel <= adr_sel;
      end
    end
  end

  // Ack in the access phase, qualified by the strobe.
  assign ack = (state != idle) && cyc && stb;

  // Write strobe only in an acknowledged write.
  assign wr_stb = (state == write) && cyc && stb;

endmodule

//--- iwdg_reg_bank.sv
// Watchdog register bank.
// Key, prescale, reload and status registers.
// Prescale and reload writes are locked unless the key
// register holds key_access. Status bits are set by events
// and cleared by writing ones. Read data is gated by ack.

module iwdg_reg_bank (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 wr_stb,
  input  iwdg_bus_pkg::reg_sel_e               reg_sel,
  input  logic [iwdg_bus_pkg::data_w-1:0]      wr_data,
  input  logic                                 ack,
  output logic [iwdg_bus_pkg::data_w-1:0]      rd_data,
  output logic                                 run,
  output logic                                 reload,
  output logic                                 presc_load,
  output logic [iwdg_reg_pkg::pr_w-1:0]        pr_code,
  output logic [iwdg_reg_pkg::rlr_w-1:0]       rlr_val
);

  import iwdg_bus_pkg::*;
  import iwdg_reg_pkg::*;

  key_e            kr;
  logic [st_w-1:0] st;
  logic            unlocked;
  logic            pr_accept;
  logic            rlr_accept;
  logic [st_w-1:0] st_set;
  logic [st_w-1:0] st_clr;

  // Write protection.
  assign unlocked = (kr == key_access);

  // Prescale write needs the unlock and a legal code.
  assign pr_accept = wr_stb && (reg_sel == sel_pr) && unlocked &&
                     (wr_data <= data_w'(pr_max));

  assign rlr_accept = wr_stb && (reg_sel == sel_rlr) && unlocked;

  // Status events.
  // Bit 1 keeps setting for as long as the reload key is held.
  assign st_set = {reload, pr_accept};

  // Write-one-to-clear on the status register.
  assign st_clr = (wr_stb && reg_sel == sel_st) ? wr_data[st_w-1:0] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      kr         <= key_idle;
      pr_code    <= '0;
      rlr_val    <= rlr_reset;
      st         <= '0;
      presc_load <= 1'b0;
    end else begin
      // Key register takes any value.
      if (wr_stb && reg_sel == sel_kr) begin
        kr <= key_e'(wr_data);
      end
      if (pr_accept) begin
        pr_code <= wr_data[pr_w-1:0];
      end
      if (rlr_accept) begin
        rlr_val <= wr_data[rlr_w-1:0];
      end
      // A set in the same cycle wins over a clear.
      st <= (st & ~st_clr) | st_set;
      // Pulse one cycle late so the counter sees the new code.
      presc_load <= pr_accept;
    end
  end

  // Counter controls follow the key register.
  assign run    = (kr == key_count);
  assign reload = (kr == key_reload);

  // Read multiplexer.
  // Zero outside the ack cycle and for unmapped addresses.
  always_comb begin
    rd_data = '0;
    if (ack) begin
      case (reg_sel)
        sel_kr:  rd_data = kr;
        sel_pr:  rd_data = {{(data_w - pr_w){1'b0}}, pr_code};
        sel_rlr: rd_data = {{(data_w - rlr_w){1'b0}}, rlr_val};
        sel_st:  rd_data = {{(data_w - st_w){1'b0}}, st};
        default: rd_data = '0;
      endcase
    end
  end

endmodule

//--- iwdg_down_counter.sv
// Watchdog prescaler and down counter.
// The prescaler divides clk by 4 << pr_code and ticks the
// down counter. A tick at count 0 gives a one-cycle
// watchdog reset pulse and reloads the counter.

module iwdg_down_counter (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             run,
  input  logic                             reload,
  input  logic                             presc_load,
  input  logic [iwdg_reg_pkg::pr_w-1:0]    pr_code,
  input  logic [iwdg_reg_pkg::rlr_w-1:0]   rlr_val,
  output logic                             iwdg_rst
);

  import iwdg_reg_pkg::*;

  logic [presc_w:0]   divider;
  logic [presc_w-1:0] presc_top;
  logic [presc_w-1:0] presc;
  logic [rlr_w-1:0]   cnt;
  logic               tick;

  // Divide ratio, 4 up to 256.
  // One bit wider than the prescaler to hold 256.
  assign divider = (presc_w + 1)'(4) << pr_code;

  // Prescaler start value.
  assign presc_top = presc_w'(divider - 1'b1);

  // Prescaler wraps while counting.
  assign tick = run && (presc == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      // Divide by 4 and full count after reset.
      presc <= presc_w'(3);
      cnt   <= rlr_reset;
    end else if (reload) begin
      // Refresh holds both counters at their start values.
      presc <= presc_top;
      cnt   <= rlr_val;
    end else if (presc_load) begin
      // New divide ratio restarts the current prescale period.
      presc <= presc_top;
    end else if (run) begin
      if (tick) begin
        presc <= presc_top;
        if (cnt == '0) begin
          cnt <= rlr_val;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end else begin
        presc <= presc - 1'b1;
      end
    end
  end

  // Timeout pulse.
  // High only in the tick cycle that finds the count at zero.
  assign iwdg_rst = tick && (cnt == '0);

endmodule

//--- iwdg_top.sv
// Watchdog timer top level.
// Bus slave control, register bank and down counter,
// all on clk with a synchronous reset.

module iwdg_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cyc,
  input  logic                              stb,
  input  logic                              we,
  input  logic [31:0]                       adr,
  input  logic [iwdg_bus_pkg::data_w-1:0]   wr_data,
  output logic [iwdg_bus_pkg::data_w-1:0]   rd_data,
  output logic                              ack,
  output logic                              iwdg_rst
);

  import iwdg_bus_pkg::*;
  import iwdg_reg_pkg::*;

  // Bus control to registers.
  reg_sel_e         reg_sel;
  logic             wr_stb;

  // Registers to counter.
  logic             run;
  logic             reload;
  logic             presc_load;
  logic [pr_w-1:0]  pr_code;
  logic [rlr_w-1:0] rlr_val;

  iwdg_bus_fsm u_bus_fsm (
    .clk     (clk),
    .rst     (rst),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .ack     (ack),
    .wr_stb  (wr_stb),
    .reg_sel (reg_sel)
  );

  iwdg_reg_bank u_reg_bank (
    .clk        (clk),
    .rst        (rst),
    .wr_stb     (wr_stb),
    .reg_sel    (reg_sel),
    .wr_data    (wr_data),
    .ack        (ack),
    .rd_data    (rd_data),
    .run        (run),
    .reload     (reload),
    .presc_load (presc_load),
    .pr_code    (pr_code),
    .rlr_val    (rlr_val)
  );

  iwdg_down_counter u_down_counter (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .reload     (reload),
    .presc_load (presc_load),
    .pr_code    (pr_code),
    .rlr_val    (rlr_val),
    .iwdg_rst   (iwdg_rst)
  );

endmodule

//--- iwdg_tb.sv
// Testbench for the watchdog timer.
// Bus read and write tasks with a register shadow model,
// a reference function for the timeout period, a monitor
// that checks pulse width and spacing, and a run watchdog.

module iwdg_tb;

  import iwdg_bus_pkg::*;
  import iwdg_reg_pkg::*;

  // Cycles to wait for an ack before giving up.
  localparam int ack_limit = 8;

  logic              clk;
  logic              rst;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [31:0]       adr;
  logic [data_w-1:0] wr_data;
  logic [data_w-1:0] rd_data;
  logic              ack;
  logic              iwdg_rst;

  // Shadow copies of the four registers.
  logic [data_w-1:0] sh_kr;
  logic [pr_w-1:0]   sh_pr;
  logic [rlr_w-1:0]  sh_rlr;
  logic [st_w-1:0]   sh_st;

  int seed = 86;
  int cycle_cnt = 0;
  int last_ack_cycle = 0;

  // Pulse monitor state.
  int   pulse_count = 0;
  int   last_pulse_cycle = 0;
  logic pulse_seen = 1'b0;
  logic pulse_allowed = 1'b1;
  logic gap_check = 1'b0;
  logic pulse_prev = 1'b0;

  iwdg_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .wr_data  (wr_data),
    .rd_data  (rd_data),
    .ack      (ack),
    .iwdg_rst (iwdg_rst)
  );

  // Period of 20.
  always #10 clk = ~clk;

  // Free-running cycle count read at the falling edge.
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Cycles from a fresh start to a pulse.
  function automatic int expected_period(input int rlr, input int pr);
    return (rlr + 1) * (4 << pr);
  endfunction

  // Predicted read data.
  function automatic logic [data_w-1:0] model_read(input logic [31:0] a);
    logic [data_w-1:0] v;
    v = '0;
    case (a)
      kr_adr:  v = sh_kr;
      pr_adr:  v = {{(data_w - pr_w){1'b0}}, sh_pr};
      rlr_adr: v = {{(data_w - rlr_w){1'b0}}, sh_rlr};
      st_adr:  v = {{(data_w - st_w){1'b0}}, sh_st};
      default: v = '0;
    endcase
    return v;
  endfunction

  // Shadow update for a completed write.
  function automatic void model_write(input logic [31:0] a, input logic [data_w-1:0] d);
    case (a)
      kr_adr: begin
        sh_kr = d;
        // Reload key sets the status flag right away.
        if (d == key_reload) begin
          sh_st[1] = 1'b1;
        end
      end
      pr_adr: begin
        if (sh_kr == key_access && d <= data_w'(pr_max)) begin
          sh_pr    = d[pr_w-1:0];
          sh_st[0] = 1'b1;
        end
      end
      rlr_adr: begin
        if (sh_kr == key_access) begin
          sh_rlr = d[rlr_w-1:0];
        end
      end
      st_adr: begin
        sh_st = sh_st & ~d[st_w-1:0];
        if (sh_kr == key_reload) begin
          sh_st[1] = 1'b1;
        end
      end
      default: begin
      end
    endcase
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input int exp, input int got);
    if (exp != got) begin
      abort_run($sformatf("Mismatch %s exp %h got %h", name, exp, got));
    end
  endtask

  // One bus access that starts and ends 2 after a rising edge.
  task automatic run_access(input logic write_en, input logic [31:0] a,
                            input logic [data_w-1:0] d, output logic [data_w-1:0] q);
    int waited;
    waited = 0;
    cyc     = 1'b1;
    stb     = 1'b1;
    we      = write_en;
    adr     = a;
    wr_data = d;
    @(negedge clk);
    while (!ack && waited < ack_limit) begin
      waited++;
      @(negedge clk);
    end
    if (!ack) begin
      abort_run($sformatf("No ack for the access to address %h", a));
    end
    // Ack must follow the edge that sampled cyc.
    check_value("ack latency", 1, waited);
    q = rd_data;
    last_ack_cycle = cycle_cnt;
    @(posedge clk);
    #2;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    wr_data = '0;
  endtask

  task automatic bus_write(input logic [31:0] a, input logic [data_w-1:0] d);
    logic [data_w-1:0] q;
    run_access(1'b1, a, d, q);
    model_write(a, d);
  endtask

  task automatic bus_read(input logic [31:0] a, output logic [data_w-1:0] q);
    run_access(1'b0, a, '0, q);
  endtask

  // Read and compare against the shadow model.
  task automatic read_check(input logic [31:0] a, input string name);
    logic [data_w-1:0] q;
    bus_read(a, q);
    check_value(name, 32'(model_read(a)), 32'(q));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic wait_pulse(input int limit);
    int start_count;
    int waited;
    start_count = pulse_count;
    waited = 0;
    while (pulse_count == start_count && waited < limit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (pulse_count == start_count) begin
      abort_run("No watchdog reset pulse within the expected time");
    end
  endtask

  // Pulse monitor.
  // Checks the width, the refresh window and the spacing of pulses.
  always @(negedge clk) begin
    if (rst) begin
      pulse_prev = 1'b0;
    end else begin
      if (iwdg_rst) begin
        if (pulse_prev) begin
          abort_run("Watchdog reset pulse lasted longer than one cycle");
        end
        if (!pulse_allowed) begin
          abort_run("Watchdog reset pulse while the reload key was held");
        end
        if (gap_check && pulse_seen) begin
          check_value("iwdg_rst gap", expected_period(32'(sh_rlr), 32'(sh_pr)),
                      cycle_cnt - last_pulse_cycle);
        end
        pulse_seen       = 1'b1;
        last_pulse_cycle = cycle_cnt;
        pulse_count++;
      end
      pulse_prev = iwdg_rst;
    end
  end

  // Run watchdog.
  // Bounds the bus traffic plus a dozen of the longest periods.
  initial begin
    int limit;
    limit = 10 + 80 * (ack_limit + 2) + 12 * expected_period(20, 2) + 500;
    repeat (limit) @(posedge clk);
    abort_run("Timeout, the run took longer than the tests allow");
  end

  initial begin
    int r;
    int rlr_i;
    int pr_i;
    int period;
    logic [data_w-1:0] q;
    clk     = 1'b0;
    rst     = 1'b1;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    adr     = '0;
    wr_data = '0;
    sh_kr   = key_idle;
    sh_pr   = '0;
    sh_rlr  = rlr_reset;
    sh_st   = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    // Reset values and an unmapped address.
    read_check(kr_adr, "rd_data kr");
    read_check(pr_adr, "rd_data pr");
    read_check(rlr_adr, "rd_data rlr");
    read_check(st_adr, "rd_data st");
    bus_read(base_adr + 32'h10, q);
    check_value("rd_data unmapped", 0, 32'(q));
    bus_write(base_adr + 32'h10, 16'hFFFF);
    read_check(kr_adr, "rd_data kr");
    read_check(rlr_adr, "rd_data rlr");

    // Locked writes leave prescale and reload alone.
    // The values always differ from the reset contents.
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      bus_write(pr_adr, 16'(1 + ((r & 32'h7FFF_FFFF) % 6)));
      r = $random(seed);
      bus_write(rlr_adr, 16'(r & 32'h7FF));
      read_check(pr_adr, "rd_data pr");
      read_check(rlr_adr, "rd_data rlr");
    end
    read_check(st_adr, "rd_data st");

    // Unlocked writes go through and flag the prescale update.
    bus_write(kr_adr, key_access);
    read_check(kr_adr, "rd_data kr");
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      bus_write(pr_adr, 16'((r & 32'h7FFF_FFFF) % 7));
      r = $random(seed);
      bus_write(rlr_adr, 16'(r & 32'hFFF));
      read_check(pr_adr, "rd_data pr");
      read_check(rlr_adr, "rd_data rlr");
    end
    read_check(st_adr, "rd_data st");
    // Code 7 is out of range.
    bus_write(pr_adr, 16'd7);
    read_check(pr_adr, "rd_data pr");

    // Countdown from a fresh load.
    r = $random(seed);
    rlr_i = 1 + ((r & 32'h7FFF_FFFF) % 20);
    r = $random(seed);
    pr_i = (r & 32'h7FFF_FFFF) % 3;
    bus_write(pr_adr, 16'(pr_i));
    bus_write(rlr_adr, 16'(rlr_i));
    read_check(pr_adr, "rd_data pr");
    read_check(rlr_adr, "rd_data rlr");
    bus_write(kr_adr, key_reload);
    period = expected_period(rlr_i, pr_i);
    pulse_seen = 1'b0;
    gap_check  = 1'b1;
    bus_write(kr_adr, key_count);
    wait_pulse(period + 8);
    check_value("iwdg_rst delay", period, last_pulse_cycle - last_ack_cycle);
    wait_pulse(period + 8);

    // Refresh holds off the pulse.
    pulse_allowed = 1'b0;
    gap_check     = 1'b0;
    bus_write(kr_adr, key_reload);
    wait_cycles(3 * period);
    bus_read(st_adr, q);
    check_value("rd_data st bit 1", 1, 32'(q[1]));
    check_value("rd_data st", 32'(model_read(st_adr)), 32'(q));
    pulse_seen    = 1'b0;
    gap_check     = 1'b1;
    pulse_allowed = 1'b1;
    bus_write(kr_adr, key_count);
    wait_pulse(period + 8);
    check_value("iwdg_rst delay", period, last_pulse_cycle - last_ack_cycle);
    wait_pulse(period + 8);

    // Write ones to clear both status bits.
    bus_write(st_adr, 16'h0003);
    bus_read(st_adr, q);
    check_value("rd_data st", 0, 32'(q));
    read_check(kr_adr, "rd_data kr");

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- iwdg_top.f
iwdg_bus_pkg.sv
iwdg_reg_pkg.sv
iwdg_bus_fsm.sv
iwdg_reg_bank.sv
iwdg_down_counter.sv
iwdg_top.sv
iwdg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the watchdog timer testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module iwdg_tb \
  -f iwdg_top.f --Mdir obj_dir -o iwdg_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/iwdg_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
fi

grep -q "^TEST PASSED$" "$log"
grep_status=$?
if [ $grep_status -eq 0 ]; then
  echo "Result: pass"
  exit 0
fi

echo "Result: fail"
exit 1
